//--- verilog/ball_link_pkg.sv
package ball_link_pkg;

    // address byte of the one telemetry target
    localparam logic [7:0] target_addr = 8'haa;

    // data bytes that follow the address in every frame
    localparam int frame_data_bytes = 6;

    // clock cycles per quarter of an SCL period
    localparam int scl_quarter_cycles = 4;

    // wide enough to count up to frame_data_bytes
    typedef logic [2:0] byte_idx_t;

    // game state captured on the trigger
    typedef struct packed {
        logic [9:0] y;
        logic [7:0] vy;
        logic [1:0] gravity;
        logic       collision;
        logic       lose;
    } ball_snapshot_t;

    // Frame byte mapping, in send order after the address byte:
    //   byte 0  y[9:8] in bits 7:6, zeros below
    //   byte 1  y[7:0]
    //   byte 2  vy
    //   byte 3  gravity, zero-extended
    //   byte 4  collision, zero-extended
    //   byte 5  lose, zero-extended

    // sender states, one-hot so they drive status_led directly
    typedef enum logic [6:0] {
        idle       = 7'b000_0001,
        start_wait = 7'b000_0010,
        byte_wait  = 7'b000_0100,
        send_byte  = 7'b000_1000,
        stop       = 7'b001_0000,
        done_wait  = 7'b010_0000,
        done       = 7'b100_0000
    } link_state_t;

endpackage

//--- verilog/i2c_byte_if.sv
`timescale 1ns/1ps

interface i2c_byte_if;

    logic       start_req;
    logic       stop_req;
    logic       byte_req;
    logic [7:0] tx_data;
    // high while the master is idle
    logic       ready;
    // valid once ready rises after a byte
    logic       ack_ok;

    modport requester (
        output start_req, stop_req, byte_req, tx_data,
        input  ready, ack_ok
    );

    modport responder (
        input  start_req, stop_req, byte_req, tx_data,
        output ready, ack_ok
    );

endinterface

//--- verilog/ball_frame_sender.sv
`timescale 1ns/1ps

module ball_frame_sender (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          send_trigger,
    input  ball_link_pkg::ball_snapshot_t snapshot,
    i2c_byte_if.requester                 link,
    output logic                          frame_done,
    output logic                          frame_nack,
    output logic                          busy,
    output logic [7:0]                    status_led
);

    import ball_link_pkg::*;

    link_state_t state;
    byte_idx_t   byte_idx;
    logic        nack_seen;
    logic [7:0]  tx_byte;
    logic [7:0]  frame_bytes [frame_data_bytes];

    logic trigger_taken;
    logic byte_back;
    logic all_sent;

    // trigger only counts in idle, a busy sender drops it
    assign trigger_taken = (state == idle) && send_trigger;

    // master finished the last request
    assign byte_back = (state == byte_wait) && link.ready;

    assign all_sent = (byte_idx == byte_idx_t'(frame_data_bytes));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= idle;
            byte_idx  <= '0;
            nack_seen <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (send_trigger) begin
                        state     <= start_wait;
                        byte_idx  <= '0;
                        nack_seen <= 1'b0;
                    end
                end

                // hold start_req until the master takes it
                start_wait: begin
                    if (!link.ready) begin
                        state <= byte_wait;
                    end
                end

                byte_wait: begin
                    if (link.ready) begin
                        if (!link.ack_ok) begin
                            // target refused, close the frame early
                            nack_seen <= 1'b1;
                            state     <= stop;
                        end else if (all_sent) begin
                            state <= stop;
                        end else begin
                            state <= send_byte;
                        end
                    end
                end

                send_byte: begin
                    if (!link.ready) begin
                        byte_idx <= byte_idx + 1'b1;
                        state    <= byte_wait;
                    end
                end

                stop: begin
                    if (!link.ready) begin
                        state <= done_wait;
                    end
                end

                done_wait: begin
                    if (link.ready) begin
                        state <= done;
                    end
                end

                done: begin
                    state <= idle;
                end

                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // snapshot bytes and the byte on offer
    always_ff @(posedge clk) begin
        if (trigger_taken) begin
            frame_bytes[0] <= {snapshot.y[9:8], 6'b0};
            frame_bytes[1] <= snapshot.y[7:0];
            frame_bytes[2] <= snapshot.vy;
            frame_bytes[3] <= {6'b0, snapshot.gravity};
            frame_bytes[4] <= {7'b0, snapshot.collision};
            frame_bytes[5] <= {7'b0, snapshot.lose};
            tx_byte        <= target_addr;
        end else if (byte_back && link.ack_ok && !all_sent) begin
            tx_byte <= frame_bytes[byte_idx];
        end
    end

    assign link.start_req = (state == start_wait);
    assign link.byte_req  = (state == send_byte);
    assign link.stop_req  = (state == stop);
    assign link.tx_data   = tx_byte;

    assign frame_done = (state == done);
    assign frame_nack = (state == done) && nack_seen;
    assign busy       = (state != idle);

    // state is already one-hot
    assign status_led = {1'b0, state};

endmodule

//--- verilog/i2c_byte_master.sv
`timescale 1ns/1ps

module i2c_byte_master (
    input  logic          clk,
    input  logic          reset,
    i2c_byte_if.responder link,
    output logic          scl,
    output logic          sda_pull_low,
    input  logic          sda_in
);

    import ball_link_pkg::*;

    typedef enum logic [2:0] {
        bus_idle,
        bus_start,
        bus_bits,
        bus_hold,
        bus_stop
    } bus_state_t;

    bus_state_t bus_state;

    logic [$clog2(scl_quarter_cycles)-1:0] q_cnt;
    logic [1:0] qtr;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic       ready_q;
    logic       ack_q;

    logic tick;
    logic phase_end;
    logic take_byte;

    // one quarter of SCL elapsed
    assign tick      = (q_cnt == scl_quarter_cycles - 1);
    assign phase_end = tick && (qtr == 2'd3);

    // new byte accepted, either with START or while holding the bus
    assign take_byte = ((bus_state == bus_idle) && link.start_req) ||
                       ((bus_state == bus_hold) && link.byte_req);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_state <= bus_idle;
            q_cnt     <= '0;
            qtr       <= 2'd0;
            bit_cnt   <= 4'd0;
            ready_q   <= 1'b1;
            ack_q     <= 1'b0;
        end else begin
            case (bus_state)
                bus_idle: begin
                    q_cnt <= '0;
                    qtr   <= 2'd0;
                    if (link.start_req) begin
                        bus_state <= bus_start;
                        ready_q   <= 1'b0;
                    end
                end

                // SCL parked low, waiting for the next byte or STOP
                bus_hold: begin
                    q_cnt <= '0;
                    qtr   <= 2'd0;
                    if (link.byte_req) begin
                        bus_state <= bus_bits;
                        bit_cnt   <= 4'd0;
                        ready_q   <= 1'b0;
                    end else if (link.stop_req) begin
                        bus_state <= bus_stop;
                        ready_q   <= 1'b0;
                    end
                end

                default: begin
                    if (tick) begin
                        q_cnt <= '0;
                        qtr   <= qtr + 2'd1;
                    end else begin
                        q_cnt <= q_cnt + 1'b1;
                    end

                    // ack sampled in the middle of the high time
                    if (bus_state == bus_bits && bit_cnt == 4'd8 &&
                        qtr == 2'd1 && tick) begin
                        ack_q <= !sda_in;
                    end

                    if (phase_end) begin
                        case (bus_state)
                            bus_start: begin
                                bus_state <= bus_bits;
                                bit_cnt   <= 4'd0;
                            end
                            bus_bits: begin
                                if (bit_cnt == 4'd8) begin
                                    bus_state <= bus_hold;
                                    ready_q   <= 1'b1;
                                end else begin
                                    bit_cnt <= bit_cnt + 4'd1;
                                end
                            end
                            default: begin
                                bus_state <= bus_idle;
                                ready_q   <= 1'b1;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // data shifts out MSB first, moved on while SCL is low
    always_ff @(posedge clk) begin
        if (take_byte) begin
            shift <= link.tx_data;
        end else if (bus_state == bus_bits && phase_end) begin
            shift <= {shift[6:0], 1'b0};
        end
    end

    // quarters per phase:
    //   start  SCL 1 1 1 0, SDA pulled from the 2nd quarter
    //   bit    SCL 0 1 1 0, SDA stable for the whole bit
    //   stop   SCL 0 1 1 1, SDA released in the last quarter
    always_comb begin
        scl          = 1'b1;
        sda_pull_low = 1'b0;
        case (bus_state)
            bus_start: begin
                scl          = (qtr != 2'd3);
                sda_pull_low = (qtr != 2'd0);
            end
            bus_bits: begin
                scl          = (qtr == 2'd1) || (qtr == 2'd2);
                // ack bit leaves SDA to the target
                sda_pull_low = (bit_cnt < 4'd8) && !shift[7];
            end
            bus_hold: begin
                scl = 1'b0;
            end
            bus_stop: begin
                scl          = (qtr != 2'd0);
                sda_pull_low = (qtr != 2'd3);
            end
            default: begin
                scl = 1'b1;
            end
        endcase
    end

    assign link.ready  = ready_q;
    assign link.ack_ok = ack_q;

endmodule

//--- verilog/ball_link_top.sv
`timescale 1ns/1ps

module ball_link_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       send_trigger,
    input  logic [9:0] ball_y,
    input  logic [7:0] ball_vy,
    input  logic [1:0] gravity_step,
    input  logic       collision,
    input  logic       lose,
    output logic       scl,
    output logic       sda_pull_low,
    input  logic       sda_in,
    output logic       frame_done,
    output logic       frame_nack,
    output logic       busy,
    output logic [7:0] status_led
);

    import ball_link_pkg::*;

    ball_snapshot_t snapshot;

    i2c_byte_if link_if ();

    assign snapshot.y         = ball_y;
    assign snapshot.vy        = ball_vy;
    assign snapshot.gravity   = gravity_step;
    assign snapshot.collision = collision;
    assign snapshot.lose      = lose;

    ball_frame_sender i_sender (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .snapshot     (snapshot),
        .link         (link_if.requester),
        .frame_done   (frame_done),
        .frame_nack   (frame_nack),
        .busy         (busy),
        .status_led   (status_led)
    );

    i2c_byte_master i_master (
        .clk          (clk),
        .reset        (reset),
        .link         (link_if.responder),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda_in)
    );

endmodule

//--- testbench/i2c_target_model.sv
`timescale 1ns/1ps

module i2c_target_model (
    input  logic       reset,
    input  logic       scl,
    input  logic       sda,
    // frame position to refuse, 0 is the address byte
    input  logic [3:0] nack_pos,
    output logic       ack_drive
);

    logic [7:0] rx_bytes [0:15];
    logic [7:0] shift_in;
    int         bit_cnt;
    int         rx_count;
    int         start_count;
    int         stop_count;
    logic       in_frame;

    initial begin
        ack_drive   = 1'b0;
        shift_in    = 8'h00;
        bit_cnt     = 0;
        rx_count    = 0;
        start_count = 0;
        stop_count  = 0;
        in_frame    = 1'b0;
    end

    // START: SDA falls while SCL is high
    always @(negedge sda) begin
        if (!reset && scl === 1'b1) begin
            in_frame    = 1'b1;
            bit_cnt     = 0;
            rx_count    = 0;
            start_count = start_count + 1;
        end
    end

    // STOP: SDA rises while SCL is high
    always @(posedge sda) begin
        if (!reset && scl === 1'b1 && in_frame) begin
            in_frame   = 1'b0;
            ack_drive  = 1'b0;
            stop_count = stop_count + 1;
        end
    end

    always @(posedge scl) begin
        if (!reset && in_frame) begin
            if (bit_cnt < 8) begin
                shift_in = {shift_in[6:0], sda};
                bit_cnt  = bit_cnt + 1;
                if (bit_cnt == 8 && rx_count < 16) begin
                    rx_bytes[rx_count] = shift_in;
                    rx_count           = rx_count + 1;
                end
            end else begin
                // ack clock
                bit_cnt = 0;
            end
        end
    end

    // ack driven over the ninth clock, released after it
    always @(negedge scl) begin
        if (!reset && in_frame) begin
            if (bit_cnt == 8) begin
                ack_drive = ((rx_count - 1) != int'(nack_pos));
            end else begin
                ack_drive = 1'b0;
            end
        end
    end

endmodule

//--- testbench/tb_ball_link.sv
`timescale 1ns/1ps

module tb_ball_link;

    import ball_link_pkg::*;

    localparam int frame_cycles = ((frame_data_bytes + 1) * 36 + 8) * scl_quarter_cycles + 160;

    logic       clk;
    logic       reset;
    logic       send_trigger;
    logic [9:0] ball_y;
    logic [7:0] ball_vy;
    logic [1:0] gravity_step;
    logic       collision;
    logic       lose;
    logic       scl;
    logic       sda_pull_low;
    logic       sda;
    logic       frame_done;
    logic       frame_nack;
    logic       busy;
    logic [7:0] status_led;
    logic [3:0] nack_pos;
    logic       ack_drive;

    ball_snapshot_t stim_snap [0:63];
    logic [3:0]     stim_nack [0:63];
    int             stim_gap  [0:63];
    int             n_frames;
    int             limit_cycles;
    logic           stim_loaded;
    int             seed;

    // open drain bus pulled low by either side
    assign sda = (sda_pull_low || ack_drive) ? 1'b0 : 1'b1;

    ball_link_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_step (gravity_step),
        .collision    (collision),
        .lose         (lose),
        .scl          (scl),
        .sda_pull_low (sda_pull_low),
        .sda_in       (sda),
        .frame_done   (frame_done),
        .frame_nack   (frame_nack),
        .busy         (busy),
        .status_led   (status_led)
    );

    i2c_target_model i_target (
        .reset     (reset),
        .scl       (scl),
        .sda       (sda),
        .nack_pos  (nack_pos),
        .ack_drive (ack_drive)
    );

    always #4 clk = ~clk;

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // frame position 0 is the address byte
    function automatic logic [7:0] frame_byte(input ball_snapshot_t s, input int pos);
        case (pos)
            0:       frame_byte = target_addr;
            1:       frame_byte = {s.y[9:8], 6'b0};
            2:       frame_byte = s.y[7:0];
            3:       frame_byte = s.vy;
            4:       frame_byte = {6'b0, s.gravity};
            5:       frame_byte = {7'b0, s.collision};
            default: frame_byte = {7'b0, s.lose};
        endcase
    endfunction

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        logic [9:0] y;
        logic [7:0] vy;
        logic [1:0] g;
        logic c;
        logic l;
        logic [3:0] k;
        int gap;
        fd = $fopen("testbench/ball_link_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("TEST FAILED");
            $fatal(1);
        end
        n_frames = 0;
        while (!$feof(fd) && n_frames < 64) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", y, vy, g, c, l, k, gap);
                if (n == 7) begin
                    stim_snap[n_frames] = '{y: y, vy: vy, gravity: g, collision: c, lose: l};
                    stim_nack[n_frames] = k;
                    stim_gap[n_frames]  = gap + ($random(seed) & 32'h1f);
                    limit_cycles = limit_cycles + frame_cycles + stim_gap[n_frames];
                    n_frames = n_frames + 1;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_frame(input int f);
        ball_snapshot_t snap;
        logic exp_nack;
        int   exp_count;
        int   starts0;
        int   stops0;
        snap      = stim_snap[f];
        exp_nack  = (int'(stim_nack[f]) <= frame_data_bytes);
        exp_count = exp_nack ? int'(stim_nack[f]) + 1 : frame_data_bytes + 1;
        starts0   = i_target.start_count;
        stops0    = i_target.stop_count;
        @(negedge clk);
        nack_pos     = stim_nack[f];
        ball_y       = snap.y;
        ball_vy      = snap.vy;
        gravity_step = snap.gravity;
        collision    = snap.collision;
        lose         = snap.lose;
        send_trigger = 1'b1;
        @(negedge clk);
        send_trigger = 1'b0;
        check_flag(busy, 1'b1, "busy after trigger");
        // a trigger with other values while busy must be dropped
        repeat (20) @(negedge clk);
        ball_y       = ~snap.y;
        ball_vy      = ~snap.vy;
        gravity_step = ~snap.gravity;
        send_trigger = 1'b1;
        @(negedge clk);
        send_trigger = 1'b0;
        while (!frame_done) begin
            check_flag(busy, 1'b1, "busy during frame");
            @(negedge clk);
        end
        check_flag(frame_nack, exp_nack, "frame_nack at frame_done");
        check_byte(8'(i_target.rx_count), 8'(exp_count), "bytes seen by target");
        for (int i = 0; i < exp_count; i++) begin
            check_byte(i_target.rx_bytes[i], frame_byte(snap, i), $sformatf("frame byte %0d", i));
        end
        check_byte(8'(i_target.start_count - starts0), 8'd1, "START count");
        check_byte(8'(i_target.stop_count - stops0), 8'd1, "STOP count");
        @(negedge clk);
        check_flag(frame_done, 1'b0, "frame_done longer than one cycle");
        check_flag(busy, 1'b0, "busy after frame_done");
        check_led(status_led, 8'h01, "status_led back in idle");
        repeat (stim_gap[f]) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "busy in idle gap");
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_flag($onehot(status_led), 1'b1, "status_led one-hot");
        end
    end

    initial begin
        wait (stim_loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("simulation timed out before all frames finished");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        stim_loaded  = 1'b0;
        clk          = 1'b0;
        reset        = 1'b1;
        send_trigger = 1'b0;
        ball_y       = '0;
        ball_vy      = '0;
        gravity_step = '0;
        collision    = 1'b0;
        lose         = 1'b0;
        nack_pos     = 4'd7;
        seed         = 32'hc7647d5d;
        limit_cycles = 64;
        load_stim();
        stim_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_led(status_led, 8'b0000_0001, "status_led after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(frame_done, 1'b0, "frame_done after reset");
        check_flag(frame_nack, 1'b0, "frame_nack after reset");
        check_flag(scl, 1'b1, "scl after reset");
        check_flag(sda, 1'b1, "sda released after reset");
        for (int f = 0; f < n_frames; f++) begin
            run_frame(f);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- testbench/ball_link_stim.txt
# columns, all hex: y vy gravity collision lose nack_pos idle_gap
# nack_pos 0 refuses the address, 1 to 6 a data byte, 7 means no nack
155 3c 1 0 0 7 10
3ff ff 3 1 1 7 08
000 00 0 0 0 7 0c
2a5 81 2 1 0 7 20
0c3 7e 1 0 1 0 10
1ff 40 2 1 1 3 10
300 a5 3 0 1 6 10
07f 11 0 1 0 1 10
200 fe 2 0 0 7 10
3ff 00 3 1 1 5 08
100 80 1 1 0 2 0c
0ff 7f 0 0 1 4 10
2aa 55 2 1 1 7 14
155 aa 1 0 0 7 04
3c0 0f 3 1 0 7 10
000 ff 0 0 0 6 10
3ff 01 3 1 1 7 18

//--- verilog.f
verilog/ball_link_pkg.sv
verilog/i2c_byte_if.sv
verilog/ball_frame_sender.sv
verilog/i2c_byte_master.sv
verilog/ball_link_top.sv
testbench/i2c_target_model.sv
testbench/tb_ball_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ball link testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_ball_link -o sim_ball_link

./obj_dir/sim_ball_link > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log
